/* hdl/quplsPkg.sv */
package quplsPkg;

	// ==============================
	// Opcodes and function codes
	// ==============================

	// Major opcode in the low seven bits of every instruction word
	typedef enum logic [6:0] {
		OP_R2     = 7'd2,
		OP_R2B    = 7'd3,
		OP_ADDI   = 7'd4,
		OP_SUBFI  = 7'd5,
		OP_CMPI   = 7'd6,
		OP_MULI   = 7'd7,
		OP_ANDI   = 7'd8,
		OP_ORI    = 7'd9,
		OP_EORI   = 7'd10,
		OP_SLTI   = 7'd11,
		OP_MULUI  = 7'd12,
		OP_DIVI   = 7'd13,
		OP_DIVUI  = 7'd14,
		OP_SHIFT  = 7'd16,
		OP_CSR    = 7'd17,
		OP_MOV    = 7'd18,
		OP_FLT2   = 7'd20,
		OP_FLT3   = 7'd21,
		OP_MCB    = 7'd28,
		OP_BSR    = 7'd32,
		OP_JSR    = 7'd33,
		OP_RTD    = 7'd34,
		OP_DBRA   = 7'd35,
		OP_LDB    = 7'd64,
		OP_LDBU   = 7'd65,
		OP_LDW    = 7'd66,
		OP_LDWU   = 7'd67,
		OP_LDT    = 7'd68,
		OP_LDTU   = 7'd69,
		OP_LDO    = 7'd70,
		OP_LDOU   = 7'd71,
		OP_LDH    = 7'd72,
		OP_LDA    = 7'd74,
		OP_LDX    = 7'd75,
		OP_STO    = 7'd83,
		OP_REGX   = 7'd120,
		OP_NOP    = 7'd127
	} opcode_t;

	// Function codes for OP_R2 (low group) and OP_R2B (set group)
	// Codes outside this list are unimplemented and write no register
	typedef enum logic [6:0] {
		FN_ADD   = 7'd4,
		FN_CMP   = 7'd5,
		FN_MUL   = 7'd6,
		FN_DIV   = 7'd7,
		FN_SUB   = 7'd8,
		FN_MULU  = 7'd14,
		FN_DIVU  = 7'd15,
		FN_MULH  = 7'd16,
		FN_MOD   = 7'd17,
		FN_MULUH = 7'd18,
		FN_MODU  = 7'd19,
		FN_AND   = 7'd32,
		FN_OR    = 7'd33,
		FN_EOR   = 7'd34,
		FN_ANDC  = 7'd35,
		FN_NAND  = 7'd36,
		FN_NOR   = 7'd37,
		FN_ENOR  = 7'd38,
		FN_ORC   = 7'd39,
		FN_SEQ   = 7'd80,
		FN_SNE   = 7'd81,
		FN_SLT   = 7'd82,
		FN_SLE   = 7'd83,
		FN_SLTU  = 7'd84,
		FN_SLEU  = 7'd85
	} func_t;

	// Register field in the word, and the full number with the bank bit on top
	typedef logic [5:0] regno_t;
	typedef logic [6:0] aregno_t;

	// ==============================
	// Instruction formats
	// ==============================

	typedef struct packed {
		logic [24:0] payload;
		opcode_t     opcode;
	} anyfmt_t;

	typedef struct packed {
		func_t   func;
		regno_t  Rb;
		regno_t  Ra;
		regno_t  Rt;
		opcode_t opcode;
	} r2fmt_t;

	typedef struct packed {
		logic [12:0] imm;
		regno_t      Ra;
		regno_t      Rt;
		opcode_t     opcode;
	} rifmt_t;

	// These formats keep the register fields where the immediate form has them
	typedef rifmt_t lsfmt_t;
	typedef rifmt_t csrfmt_t;
	typedef rifmt_t f2fmt_t;
	typedef rifmt_t f3fmt_t;
	typedef rifmt_t bsrfmt_t;
	typedef rifmt_t jsrfmt_t;

	// Micro-code branch, only the link bit matters to register decode
	typedef struct packed {
		logic        lk;
		logic [23:0] target;
		opcode_t     opcode;
	} mcbfmt_t;

	// One word, read through whichever format the opcode calls for
	typedef union packed {
		anyfmt_t any;
		r2fmt_t  r2;
		r2fmt_t  r2b;
		rifmt_t  ri;
		lsfmt_t  ls;
		csrfmt_t csr;
		f2fmt_t  f2;
		f3fmt_t  f3;
		mcbfmt_t mcb;
		bsrfmt_t bsr;
		jsrfmt_t jsr;
	} instruction_t;

	// Fixed targets written implicitly by some control-flow opcodes
	localparam aregno_t LINK_REG  = 7'd59;
	localparam aregno_t STACK_REG = 7'd63;
	localparam aregno_t LOOP_REG  = 7'd55;

	// Result of the register-decode step
	typedef struct packed {
		instruction_t instr;
		logic         regx;
		aregno_t      Rt;
		aregno_t      Ra;
		aregno_t      Rb;
		logic         hasRt;
		logic         hasRa;
		logic         hasRb;
	} decodeOut_t;

endpackage

/* hdl/quplsDecodeRt.sv */
`timescale 1ns/1ps

module quplsDecodeRt (
	input  quplsPkg::instruction_t instr,
	input  logic                   regx,
	output quplsPkg::aregno_t      Rt,
	output logic                   hasRt
);
	import quplsPkg::*;

	// Set when the target is one of the hard-wired registers
	logic fixedSel;

	always_comb
	begin
		Rt = '0;
		fixedSel = 1'b0;
		case (instr.any.opcode)
		OP_R2:
			// Only implemented functions produce a result register
			case (instr.r2.func)
			FN_ADD, FN_CMP, FN_MUL, FN_DIV, FN_SUB,
			FN_MULU, FN_DIVU, FN_MULH, FN_MOD, FN_MULUH, FN_MODU,
			FN_AND, FN_OR, FN_EOR, FN_ANDC, FN_NAND, FN_NOR, FN_ENOR, FN_ORC:
				Rt = {regx, instr.r2.Rt};
			default:
				Rt = '0;
			endcase
		OP_R2B:
			case (instr.r2b.func)
			FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU:
				Rt = {regx, instr.r2b.Rt};
			default:
				Rt = '0;
			endcase
		OP_FLT2:
			Rt = {regx, instr.f2.Rt};
		OP_FLT3:
			Rt = {regx, instr.f3.Rt};
		OP_MCB:
		begin
			// The link register is written only for a call-type branch
			Rt = instr.mcb.lk ? LINK_REG : '0;
			fixedSel = 1'b1;
		end
		OP_BSR:
			Rt = {regx, instr.bsr.Rt};
		OP_JSR:
			Rt = {regx, instr.jsr.Rt};
		OP_RTD:
		begin
			// Return pops the frame, so the stack pointer is updated
			Rt = STACK_REG;
			fixedSel = 1'b1;
		end
		OP_DBRA:
		begin
			// Decrement-and-branch counts in the loop register
			Rt = LOOP_REG;
			fixedSel = 1'b1;
		end
		OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI,
		OP_SLTI, OP_MULUI, OP_DIVUI, OP_ANDI, OP_ORI, OP_EORI:
			Rt = {regx, instr.ri.Rt};
		OP_SHIFT, OP_MOV:
			Rt = {regx, instr.r2.Rt};
		OP_CSR:
			Rt = {regx, instr.csr.Rt};
		OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU,
		OP_LDO, OP_LDOU, OP_LDH, OP_LDA, OP_LDX:
			Rt = {regx, instr.ls.Rt};
		default:
			Rt = '0;
		endcase

		// An upper-bank target can only come from the prefix bit
		assert (!Rt[6] || regx || fixedSel)
			else $error("Rt upper bank selected without REGX prefix");
	end

	// Register zero is never a real target
	assign hasRt = (Rt != '0);

endmodule

/* hdl/quplsDecodeSrc.sv */
`timescale 1ns/1ps

module quplsDecodeSrc (
	input  quplsPkg::instruction_t instr,
	input  logic                   regx,
	output quplsPkg::aregno_t      Ra,
	output quplsPkg::aregno_t      Rb,
	output logic                   hasRa,
	output logic                   hasRb
);
	import quplsPkg::*;

	// ==============================
	// First source, Ra
	// ==============================

	always_comb
	begin
		Ra = '0;
		hasRa = 1'b0;
		case (instr.any.opcode)
		OP_R2, OP_R2B, OP_SHIFT, OP_MOV:
		begin
			Ra = {regx, instr.r2.Ra};
			hasRa = 1'b1;
		end
		OP_FLT2:
		begin
			Ra = {regx, instr.f2.Ra};
			hasRa = 1'b1;
		end
		OP_FLT3:
		begin
			Ra = {regx, instr.f3.Ra};
			hasRa = 1'b1;
		end
		OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI,
		OP_SLTI, OP_MULUI, OP_DIVUI, OP_ANDI, OP_ORI, OP_EORI:
		begin
			Ra = {regx, instr.ri.Ra};
			hasRa = 1'b1;
		end
		// Loads and the store use Ra as the address base
		OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU,
		OP_LDO, OP_LDOU, OP_LDH, OP_LDA, OP_LDX, OP_STO:
		begin
			Ra = {regx, instr.ls.Ra};
			hasRa = 1'b1;
		end
		default:
		begin
			Ra = '0;
			hasRa = 1'b0;
		end
		endcase
	end

	// ==============================
	// Second source, Rb
	// ==============================

	// Rb sits in the func-word layout for all users, the store data included
	always_comb
	begin
		Rb = '0;
		hasRb = 1'b0;
		case (instr.any.opcode)
		OP_R2, OP_R2B, OP_FLT3, OP_SHIFT, OP_STO:
		begin
			Rb = {regx, instr.r2.Rb};
			hasRb = 1'b1;
		end
		default:
		begin
			Rb = '0;
			hasRb = 1'b0;
		end
		endcase
	end

endmodule

/* hdl/quplsDecodeStage.sv */
`timescale 1ns/1ps

module quplsDecodeStage (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   inValid,
	input  quplsPkg::instruction_t inInstr,
	output logic                   inReady,
	output logic                   outValid,
	output quplsPkg::decodeOut_t   outData,
	input  logic                   outReady
);
	import quplsPkg::*;

	// Bank bit waiting for the next real instruction
	logic regxPending;
	logic accept;
	logic isRegx;
	decodeOut_t decoded;

	// ==============================
	// Handshake
	// ==============================

	// The single output slot frees up when it is empty or drains this cycle
	assign inReady = !outValid || outReady;
	assign accept = inValid && inReady;
	assign isRegx = (inInstr.any.opcode == OP_REGX);

	// ==============================
	// Register decode
	// ==============================

	quplsDecodeRt uRt (
		.instr (inInstr),
		.regx  (regxPending),
		.Rt    (decoded.Rt),
		.hasRt (decoded.hasRt)
	);

	quplsDecodeSrc uSrc (
		.instr (inInstr),
		.regx  (regxPending),
		.Ra    (decoded.Ra),
		.Rb    (decoded.Rb),
		.hasRa (decoded.hasRa),
		.hasRb (decoded.hasRb)
	);

	// The word itself and the bank bit travel with the register numbers
	assign decoded.instr = inInstr;
	assign decoded.regx = regxPending;

	// Control state of the stage
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			outValid <= 1'b0;
			regxPending <= 1'b0;
		end
		else
		begin
			if (accept && isRegx)
			begin
				// A prefix is swallowed here, a repeated one keeps the bit set
				regxPending <= 1'b1;
				outValid <= 1'b0;
			end
			else if (accept)
			begin
				// The bank bit is spent on this word
				regxPending <= 1'b0;
				outValid <= 1'b1;
			end
			else if (outReady)
				outValid <= 1'b0;
		end
	end

	// Output payload, loaded only when a real instruction is taken
	always_ff @(posedge clk)
	begin
		if (accept && !isRegx)
			outData <= decoded;
	end

	// A stalled result must not change under the consumer
	assert property (@(posedge clk) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outData))
		else $error("outData changed while stalled");

	// A prefix never turns into an output item
	assert property (@(posedge clk) disable iff (!rstN)
		outValid |-> outData.instr.any.opcode != OP_REGX)
		else $error("REGX prefix produced an output");

endmodule

/* hdl/quplsDecodeTop.sv */
`timescale 1ns/1ps

module quplsDecodeTop (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   inValid,
	input  quplsPkg::instruction_t inInstr,
	output logic                   inReady,
	output logic                   outValid,
	output quplsPkg::decodeOut_t   outData,
	input  logic                   outReady
);
	import quplsPkg::*;

	// Interface-level result, named here so the top shows the decoded bundle
	decodeOut_t stageOut;

	// Single decode stage, one cycle from input transfer to outValid
	quplsDecodeStage uStage (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.inInstr  (inInstr),
		.inReady  (inReady),
		.outValid (outValid),
		.outData  (stageOut),
		.outReady (outReady)
	);

	assign outData = stageOut;

endmodule

/* sim/tbQuplsDecode.sv */
`timescale 1ns/1ps

module tbQuplsDecode;
	import quplsPkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_WORDS = 600;
	localparam int NUM_OPS = 37;
	localparam int NUM_FNS = 25;
	// Four cycles per word covers gaps and stalls, the rest is drain margin
	localparam int WATCHDOG_NS = NUM_WORDS * 4 * CLK_PERIOD + 200 * CLK_PERIOD;

	logic clk;
	logic rstN;
	logic inValid;
	instruction_t inInstr;
	logic inReady;
	logic outValid;
	decodeOut_t outData;
	logic outReady;

	integer seed = 32'hb830;
	int valueErrors = 0;
	int protocolErrors = 0;
	int outCount = 0;
	logic modelPending;
	decodeOut_t expQ [$];
	decodeOut_t expItem;

	opcode_t opTable [NUM_OPS] = '{
		OP_R2, OP_R2B, OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_ANDI, OP_ORI,
		OP_EORI, OP_SLTI, OP_MULUI, OP_DIVI, OP_DIVUI, OP_SHIFT, OP_CSR, OP_MOV,
		OP_FLT2, OP_FLT3, OP_MCB, OP_BSR, OP_JSR, OP_RTD, OP_DBRA, OP_LDB,
		OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDOU, OP_LDH,
		OP_LDA, OP_LDX, OP_STO, OP_REGX, OP_NOP
	};

	func_t fnTable [NUM_FNS] = '{
		FN_ADD, FN_CMP, FN_MUL, FN_DIV, FN_SUB, FN_MULU, FN_DIVU, FN_MULH,
		FN_MOD, FN_MULUH, FN_MODU, FN_AND, FN_OR, FN_EOR, FN_ANDC, FN_NAND,
		FN_NOR, FN_ENOR, FN_ORC, FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU
	};

	quplsDecodeTop DUT (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.inInstr  (inInstr),
		.inReady  (inReady),
		.outValid (outValid),
		.outData  (outData),
		.outReady (outReady)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ==============================
	// Random helpers and model
	// ==============================

	function automatic int pickBelow(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	// Random word with about one REGX in ten, function codes mostly legal
	function automatic instruction_t makeWord();
		logic [31:0] raw;
		opcode_t op;
		raw = $random(seed);
		if (pickBelow(10) == 0)
			op = OP_REGX;
		else
			op = opTable[pickBelow(NUM_OPS)];
		raw[6:0] = op;
		if ((op == OP_R2 || op == OP_R2B) && pickBelow(3) != 0)
			raw[31:25] = fnTable[pickBelow(NUM_FNS)];
		return instruction_t'(raw);
	endfunction

	// Expected decode of a non-prefix word, worked out on the raw bit fields
	function automatic decodeOut_t modelDecode(input logic [31:0] w, input logic x);
		decodeOut_t d;
		aregno_t rtField;
		aregno_t raField;
		aregno_t rbField;
		rtField = {x, w[12:7]};
		raField = {x, w[18:13]};
		rbField = {x, w[24:19]};
		d = '0;
		d.instr = instruction_t'(w);
		d.regx = x;
		case (w[6:0])
		OP_R2:
			if (w[31:25] inside {FN_ADD, FN_CMP, FN_MUL, FN_DIV, FN_SUB, FN_MULU,
				FN_DIVU, FN_MULH, FN_MOD, FN_MULUH, FN_MODU, FN_AND, FN_OR, FN_EOR,
				FN_ANDC, FN_NAND, FN_NOR, FN_ENOR, FN_ORC})
				d.Rt = rtField;
		OP_R2B:
			if (w[31:25] inside {FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU})
				d.Rt = rtField;
		OP_FLT2, OP_FLT3, OP_BSR, OP_JSR, OP_SHIFT, OP_CSR, OP_MOV,
		OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI, OP_SLTI, OP_MULUI, OP_DIVUI,
		OP_ANDI, OP_ORI, OP_EORI, OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT,
		OP_LDTU, OP_LDO, OP_LDOU, OP_LDH, OP_LDA, OP_LDX:
			d.Rt = rtField;
		OP_MCB:
			d.Rt = w[31] ? LINK_REG : 7'd0;
		OP_RTD:
			d.Rt = STACK_REG;
		OP_DBRA:
			d.Rt = LOOP_REG;
		default:
			d.Rt = 7'd0;
		endcase
		d.hasRt = (d.Rt != 7'd0);
		// Address base and ALU operand users read Ra
		if (w[6:0] inside {OP_R2, OP_R2B, OP_FLT2, OP_FLT3, OP_SHIFT, OP_MOV,
			OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI, OP_SLTI, OP_MULUI,
			OP_DIVUI, OP_ANDI, OP_ORI, OP_EORI, OP_LDB, OP_LDBU, OP_LDW, OP_LDWU,
			OP_LDT, OP_LDTU, OP_LDO, OP_LDOU, OP_LDH, OP_LDA, OP_LDX, OP_STO})
		begin
			d.Ra = raField;
			d.hasRa = 1'b1;
		end
		if (w[6:0] inside {OP_R2, OP_R2B, OP_FLT3, OP_SHIFT, OP_STO})
		begin
			d.Rb = rbField;
			d.hasRb = 1'b1;
		end
		return d;
	endfunction

	// ==============================
	// Compare tasks
	// ==============================

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			valueErrors++;
			$display("[FAIL] %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic checkReg(input string name, input aregno_t got, input logic gotHas,
		input aregno_t exp, input logic expHas);
		if (got !== exp || gotHas !== expHas)
		begin
			valueErrors++;
			$display("[FAIL] %0t: %s is %0d (used %b), expected %0d (used %b)",
				$time, name, got, gotHas, exp, expHas);
		end
	endtask

	task automatic checkOut(input decodeOut_t got, input decodeOut_t exp);
		if (got.instr !== exp.instr || got.regx !== exp.regx)
		begin
			valueErrors++;
			$display("[FAIL] %0t: word %h regx %b, expected word %h regx %b",
				$time, got.instr, got.regx, exp.instr, exp.regx);
		end
		checkReg("Rt", got.Rt, got.hasRt, exp.Rt, exp.hasRt);
		checkReg("Ra", got.Ra, got.hasRa, exp.Ra, exp.hasRa);
		checkReg("Rb", got.Rb, got.hasRb, exp.Rb, exp.hasRb);
	endtask

	// One clock step, with a fresh outReady about 70% high
	task automatic stepCycle();
		@(posedge clk);
		#5;
		outReady = (pickBelow(10) >= 3);
	endtask

	// ==============================
	// Output monitor
	// ==============================

	// Mid-cycle sampling sees the values the next rising edge will take
	always @(negedge clk)
	begin
		if (rstN)
		begin
			// The queue holds exactly the item that sits in the output slot
			checkBit("outValid", outValid, expQ.size() != 0);
			checkBit("inReady", inReady, expQ.size() == 0 || outReady);
		end
		if (rstN && outValid && outReady)
		begin
			outCount++;
			if (outData.instr.any.opcode == OP_REGX)
			begin
				protocolErrors++;
				$display("Error at %0t: a REGX prefix word came out of the stage", $time);
			end
			if (expQ.size() == 0)
			begin
				protocolErrors++;
				$display("Error at %0t: output seen while no result was expected", $time);
			end
			else
			begin
				expItem = expQ.pop_front();
				checkOut(outData, expItem);
			end
		end
	end

	// ==============================
	// Stimulus
	// ==============================

	initial
	begin
		instruction_t word;
		logic accepted;
		int i;
		int n;
		clk = 1'b0;
		rstN = 1'b0;
		inValid = 1'b0;
		inInstr = '0;
		outReady = 1'b0;
		modelPending = 1'b0;
		repeat (4) @(posedge clk);
		#5;
		rstN = 1'b1;

		// Idle state straight out of reset
		@(negedge clk);
		checkBit("outValid after reset", outValid, 1'b0);
		checkBit("inReady after reset", inReady, 1'b1);
		stepCycle();

		for (i = 0; i < NUM_WORDS; i++)
		begin
			word = makeWord();
			// Occasional bubble on the input side
			if (pickBelow(4) == 0)
				stepCycle();
			inValid = 1'b1;
			inInstr = word;
			accepted = 1'b0;
			while (!accepted)
			begin
				@(negedge clk);
				accepted = inReady;
				stepCycle();
			end
			// The word moved into the stage on the edge just passed
			if (word.any.opcode == OP_REGX)
				modelPending = 1'b1;
			else
			begin
				expQ.push_back(modelDecode(word, modelPending));
				modelPending = 1'b0;
			end
			inValid = 1'b0;
		end

		// Drain what is left, then watch a few more cycles for stray outputs
		for (n = 0; n < 100 && expQ.size() != 0; n++)
			stepCycle();
		repeat (5) stepCycle();
		if (expQ.size() != 0)
		begin
			protocolErrors++;
			$display("Error: %0d expected results never came out", expQ.size());
		end

		$display("Outputs %0d, value errors %0d, protocol errors %0d",
			outCount, valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Watchdog against a stuck handshake
	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("TB FAILED");
		$finish;
	end

endmodule

/* files.f */
hdl/quplsPkg.sv
hdl/quplsDecodeRt.sv
hdl/quplsDecodeSrc.sv
hdl/quplsDecodeStage.sv
hdl/quplsDecodeTop.sv
sim/tbQuplsDecode.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -sv
TOP      = tbQuplsDecode
FILELIST = files.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJDIR)
